// ==== mem_bus_pkg.sv ====
////////////////////////////////////////////////////////////////////////////
// Game memory bus definitions
// Byte type and request opcodes shared by the loader, CPU port, arbiter
////////////////////////////////////////////////////////////////////////////

package mem_bus_pkg;

	// Data path width of the game memory
	localparam int BYTE_W = 8;

	typedef logic [BYTE_W-1:0] byte_t;

	// Request opcode carried on the request interface
	typedef enum logic {
		MEM_READ  = 1'b0,
		MEM_WRITE = 1'b1
	} mem_op_e;

endpackage

// ==== ines_pkg.sv ====
////////////////////////////////////////////////////////////////////////////
// iNES loader definitions
// Loader states, header signature, download addresses and the layout of
// the mapper flags word
////////////////////////////////////////////////////////////////////////////

package ines_pkg;

	typedef enum logic [2:0] {
		S_HEADER = 3'd0,
		S_PRG    = 3'd1,
		S_CHR    = 3'd2,
		S_ERROR  = 3'd3,
		S_DONE   = 3'd4
	} load_state_e;

	localparam int HDR_LEN = 16;                 // Header bytes before payload

	// "NES" followed by the MS-DOS EOF byte
	localparam logic [31:0] NES_MAGIC = 32'h4E45_531A;

	// Download port register map
	localparam logic [7:0] DL_DATA_ADDR    = 8'h00;
	localparam logic [7:0] DL_RESTART_ADDR = 8'h04;

	////////////////////////////////////////////////////////////////////////////
	// Mapper flags word, unlisted bits read as zero
	////////////////////////////////////////////////////////////////////////////
	localparam int FLAG_MAPPER_LSB    = 0;       // 8 bit mapper number
	localparam int FLAG_PRG_SIZE_LSB  = 8;       // 3 bit size code
	localparam int FLAG_CHR_SIZE_LSB  = 11;      // 3 bit size code
	localparam int FLAG_MIRROR        = 14;
	localparam int FLAG_CHR_RAM       = 15;
	localparam int FLAG_FOUR_SCREEN   = 16;
	localparam int FLAG_SUBMAPPER_LSB = 17;      // NES 2.0 byte 8
	localparam int FLAG_SAVES         = 25;      // Battery backed RAM

endpackage

// ==== bus_ifs.sv ====
////////////////////////////////////////////////////////////////////////////
// Memory bus interfaces
// Peer request bus into the arbiter and the arbiter to RAM bus
////////////////////////////////////////////////////////////////////////////

// Request held until gnt, read data one cycle after the grant
interface mem_req_if import mem_bus_pkg::*; #(
	parameter int ADDR_W = 12
) ();
	logic              req;
	mem_op_e           op;
	logic [ADDR_W-1:0] addr;
	byte_t             wdata;
	logic              gnt;
	byte_t             rdata;

	modport master (output req, op, addr, wdata, input gnt, rdata);
	modport slave  (input req, op, addr, wdata, output gnt, rdata);
endinterface

// Plain single-port RAM access, one cycle read latency
interface ram_if import mem_bus_pkg::*; #(
	parameter int ADDR_W = 12
) ();
	logic              en;
	logic              we;
	logic [ADDR_W-1:0] addr;
	byte_t             wdata;
	byte_t             rdata;

	modport master (output en, we, addr, wdata, input rdata);
	modport slave  (input en, we, addr, wdata, output rdata);
endinterface

// ==== game_ram.sv ====
////////////////////////////////////////////////////////////////////////////
// Game memory
// Single port byte RAM with registered read
////////////////////////////////////////////////////////////////////////////

module game_ram import mem_bus_pkg::*; #(
	parameter int ADDR_W = 12
) (
	input  logic  clk,
	ram_if.slave  ram
);

	byte_t mem [0:2**ADDR_W-1];

	always_ff @(posedge clk) begin
		if (ram.en) begin
			if (ram.we)
				mem[ram.addr] <= ram.wdata;
			ram.rdata <= mem[ram.addr];           // Old data on a write
		end
	end

endmodule

// ==== mem_arbiter.sv ====
////////////////////////////////////////////////////////////////////////////
// Game memory arbiter
// Fixed priority, the loader always wins over the CPU port
////////////////////////////////////////////////////////////////////////////

module mem_arbiter import mem_bus_pkg::*; #(
	parameter int ADDR_W = 12
) (
	input  logic     clk,
	input  logic     reset_nes,
	mem_req_if.slave loader,
	mem_req_if.slave cpu,
	ram_if.master    ram
);

	logic              cpu_gnt;
	logic              loader_last, cpu_last;  // Owner of the read in flight
	logic [ADDR_W-1:0] sel_addr;
	mem_op_e           sel_op;

	assign loader.gnt = loader.req;
	assign cpu_gnt    = cpu.req && !loader.req;
	assign cpu.gnt    = cpu_gnt;

	assign sel_addr  = loader.req ? loader.addr : cpu.addr;
	assign sel_op    = loader.req ? loader.op : cpu.op;

	assign ram.en    = loader.req || cpu.req;
	assign ram.we    = ram.en && (sel_op == MEM_WRITE);
	assign ram.addr  = sel_addr;
	assign ram.wdata = loader.req ? loader.wdata : cpu.wdata;

	always_ff @(posedge clk) begin
		if (reset_nes) begin
			loader_last <= 1'b0;
			cpu_last    <= 1'b0;
		end else begin
			loader_last <= loader.req;
			cpu_last    <= cpu_gnt;
		end
	end

	// Read data back to last cycle's winner
	assign loader.rdata = loader_last ? ram.rdata : '0;
	assign cpu.rdata    = cpu_last ? ram.rdata : '0;

endmodule

// ==== cpu_port.sv ====
////////////////////////////////////////////////////////////////////////////
// CPU side APB slave
// Turns APB reads and writes into game memory requests
////////////////////////////////////////////////////////////////////////////

module cpu_port import mem_bus_pkg::*; #(
	parameter int ADDR_W = 12
) (
	input  logic              clk,
	input  logic              reset_nes,
	input  logic              psel,
	input  logic              penable,
	input  logic              pwrite,
	input  logic [ADDR_W-1:0] paddr,
	input  byte_t             pwdata,
	output byte_t             prdata,
	output logic              pready,
	output logic              pslverr,
	mem_req_if.master         mem
);

	logic rd_wait;                               // Read granted, data next cycle

	// Request from the first access cycle until granted
	assign mem.req   = psel && penable && !rd_wait;
	assign mem.op    = pwrite ? MEM_WRITE : MEM_READ;
	assign mem.addr  = paddr;
	assign mem.wdata = pwdata;

	always_ff @(posedge clk) begin
		if (reset_nes)
			rd_wait <= 1'b0;
		else
			rd_wait <= mem.req && mem.gnt && !pwrite;
	end

	assign pready  = rd_wait || (mem.req && mem.gnt && pwrite);
	assign prdata  = mem.rdata;                  // Registered in the RAM
	assign pslverr = 1'b0;

endmodule

// ==== ines_loader.sv ====
////////////////////////////////////////////////////////////////////////////
// iNES cartridge loader
// APB download slave that parses the 16 byte header, then copies PRG and
// CHR pages into game memory and reports the mapper flags
////////////////////////////////////////////////////////////////////////////

module ines_loader import mem_bus_pkg::*, ines_pkg::*; #(
	parameter int ADDR_W        = 12,
	parameter int PRG_PAGE_LOG2 = 8,
	parameter int CHR_PAGE_LOG2 = 7,
	parameter int CHR_BASE      = 2048
) (
	input  logic        clk,
	input  logic        reset_nes,
	input  logic        psel,
	input  logic        penable,
	input  logic        pwrite,
	input  logic [7:0]  paddr,
	input  byte_t       pwdata,
	output byte_t       prdata,
	output logic        pready,
	output logic        pslverr,
	input  logic        invert_mirroring,
	output logic [31:0] mapper_flags,
	output logic        busy,
	output logic        done,
	output logic        error,
	mem_req_if.master   mem
);

	// Each region may take up half of the memory
	localparam int PRG_MAX = 2 ** (ADDR_W - 1 - PRG_PAGE_LOG2);
	localparam int CHR_MAX = 2 ** (ADDR_W - 1 - CHR_PAGE_LOG2);
	localparam int CNT_W   = $clog2(HDR_LEN);

	load_state_e       state;
	byte_t             hdr [0:HDR_LEN-1];
	logic [CNT_W-1:0]  hdr_cnt;
	logic [ADDR_W-1:0] mem_addr;
	logic [ADDR_W-1:0] bytes_left;
	logic [ADDR_W-1:0] prg_bytes, chr_bytes;
	logic              access, data_wr, restart;
	logic              hdr_ok, is_nes20, is_dirty;
	logic [31:0]       flags;

	// Smallest k with count <= 2^k, capped at 7
	function automatic logic [2:0] size_code(input byte_t count);
		logic [2:0] code;
		code = 3'd7;
		for (int k = 6; k >= 1; k--) begin
			if (count <= (9'd1 << k))
				code = 3'(k);
		end
		if (count <= 8'd1)
			code = 3'd0;
		return code;
	endfunction

	assign access  = psel && penable;
	assign restart = access && pwrite && (paddr == DL_RESTART_ADDR);
	assign data_wr = access && pwrite && (paddr == DL_DATA_ADDR);
	assign busy    = (state == S_PRG) || (state == S_CHR);

	assign prg_bytes = ADDR_W'(int'(hdr[4]) << PRG_PAGE_LOG2);
	assign chr_bytes = ADDR_W'(int'(hdr[5]) << CHR_PAGE_LOG2);

	// Signature, no trainer, both regions fit
	assign hdr_ok = ({hdr[0], hdr[1], hdr[2], hdr[3]} == NES_MAGIC) && !hdr[6][2]
		&& (int'(hdr[4]) <= PRG_MAX) && (int'(hdr[5]) <= CHR_MAX);

	////////////////////////////////////////////////////////////////////////////
	// APB side
	////////////////////////////////////////////////////////////////////////////
	assign prdata = byte_t'(state);

	always_comb begin
		pready  = 1'b0;
		pslverr = 1'b0;
		if (access) begin
			if (!pwrite || restart) begin
				pready = 1'b1;
			end else if (paddr != DL_DATA_ADDR) begin
				pready  = 1'b1;                      // Unmapped register
				pslverr = 1'b1;
			end else begin
				case (state)
					S_HEADER:     pready = 1'b1;
					S_PRG, S_CHR: pready = mem.gnt;  // Stretched by the arbiter
					default: begin
						pready  = 1'b1;
						pslverr = 1'b1;
					end
				endcase
			end
		end
	end

	// Payload bytes go straight to memory
	assign mem.req   = data_wr && busy;
	assign mem.op    = MEM_WRITE;
	assign mem.addr  = mem_addr;
	assign mem.wdata = pwdata;

	always_ff @(posedge clk) begin
		if (state == S_HEADER && data_wr)
			hdr[hdr_cnt] <= pwdata;
	end

	always_ff @(posedge clk) begin
		if (reset_nes || restart) begin
			state      <= S_HEADER;
			hdr_cnt    <= '0;
			mem_addr   <= '0;
			bytes_left <= '0;
			done       <= 1'b0;
			error      <= 1'b0;
		end else begin
			case (state)
				S_HEADER: if (data_wr) begin
					hdr_cnt <= hdr_cnt + 1'b1;
					if (hdr_cnt == CNT_W'(HDR_LEN - 1)) begin
						if (!hdr_ok) begin
							state <= S_ERROR;
							error <= 1'b1;
							done  <= 1'b1;
						end else if (hdr[4] != '0) begin
							state      <= S_PRG;
							mem_addr   <= '0;
							bytes_left <= prg_bytes;
						end else if (hdr[5] != '0) begin
							state      <= S_CHR;
							mem_addr   <= ADDR_W'(CHR_BASE);
							bytes_left <= chr_bytes;
						end else begin
							state <= S_DONE;
							done  <= 1'b1;
						end
					end
				end
				S_PRG, S_CHR: if (data_wr && mem.gnt) begin
					mem_addr   <= mem_addr + 1'b1;
					bytes_left <= bytes_left - 1'b1;
					if (bytes_left == ADDR_W'(1)) begin   // Last byte of the stage
						if (state == S_PRG && hdr[5] != '0) begin
							state      <= S_CHR;
							mem_addr   <= ADDR_W'(CHR_BASE);
							bytes_left <= chr_bytes;
						end else begin
							state <= S_DONE;
							done  <= 1'b1;
						end
					end
				end
				default: ;                              // Held until restart
			endcase
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Mapper flags
	////////////////////////////////////////////////////////////////////////////
	assign is_nes20 = (hdr[7][3:2] == 2'b10);
	assign is_dirty = !is_nes20 && ((hdr[9][7:1] != '0) || (hdr[10] != '0)
		|| (hdr[11] != '0) || (hdr[12] != '0) || (hdr[13] != '0)
		|| (hdr[14] != '0) || (hdr[15] != '0));

	always_comb begin
		flags = '0;
		flags[FLAG_MAPPER_LSB +: 8]    = {is_dirty ? 4'h0 : hdr[7][7:4], hdr[6][7:4]};
		flags[FLAG_PRG_SIZE_LSB +: 3]  = size_code(hdr[4]);
		flags[FLAG_CHR_SIZE_LSB +: 3]  = size_code(hdr[5]);
		flags[FLAG_MIRROR]             = hdr[6][0] ^ invert_mirroring;
		flags[FLAG_CHR_RAM]            = (hdr[5] == '0);
		flags[FLAG_FOUR_SCREEN]        = hdr[6][3];
		flags[FLAG_SUBMAPPER_LSB +: 8] = is_nes20 ? hdr[8] : 8'h00;
		flags[FLAG_SAVES]              = hdr[6][1];
	end

	assign mapper_flags = (done && !error) ? flags : '0;  // Only a good load reports

endmodule

// ==== nes_loader_top.sv ====
////////////////////////////////////////////////////////////////////////////
// Cartridge loading subsystem
// Download and CPU APB ports sharing one game memory through an arbiter
////////////////////////////////////////////////////////////////////////////

module nes_loader_top import mem_bus_pkg::*; #(
	parameter int ADDR_W        = 12,
	parameter int PRG_PAGE_LOG2 = 8,
	parameter int CHR_PAGE_LOG2 = 7,
	parameter int CHR_BASE      = 2048
) (
	input  logic              clk,
	input  logic              reset_nes,

	// Download port
	input  logic              dl_psel,
	input  logic              dl_penable,
	input  logic              dl_pwrite,
	input  logic [7:0]        dl_paddr,
	input  byte_t             dl_pwdata,
	output byte_t             dl_prdata,
	output logic              dl_pready,
	output logic              dl_pslverr,

	// CPU port
	input  logic              cpu_psel,
	input  logic              cpu_penable,
	input  logic              cpu_pwrite,
	input  logic [ADDR_W-1:0] cpu_paddr,
	input  byte_t             cpu_pwdata,
	output byte_t             cpu_prdata,
	output logic              cpu_pready,
	output logic              cpu_pslverr,

	input  logic              invert_mirroring,
	output logic [31:0]       mapper_flags,
	output logic              busy,
	output logic              done,
	output logic              error
);

	mem_req_if #(.ADDR_W(ADDR_W)) loader_req ();
	mem_req_if #(.ADDR_W(ADDR_W)) cpu_req ();
	ram_if     #(.ADDR_W(ADDR_W)) ram_bus ();

	ines_loader #(
		.ADDR_W        (ADDR_W),
		.PRG_PAGE_LOG2 (PRG_PAGE_LOG2),
		.CHR_PAGE_LOG2 (CHR_PAGE_LOG2),
		.CHR_BASE      (CHR_BASE)
	) loader_inst (
		.clk              (clk),
		.reset_nes        (reset_nes),
		.psel             (dl_psel),
		.penable          (dl_penable),
		.pwrite           (dl_pwrite),
		.paddr            (dl_paddr),
		.pwdata           (dl_pwdata),
		.prdata           (dl_prdata),
		.pready           (dl_pready),
		.pslverr          (dl_pslverr),
		.invert_mirroring (invert_mirroring),
		.mapper_flags     (mapper_flags),
		.busy             (busy),
		.done             (done),
		.error            (error),
		.mem              (loader_req.master)
	);

	cpu_port #(.ADDR_W(ADDR_W)) cpu_inst (
		.clk       (clk),
		.reset_nes (reset_nes),
		.psel      (cpu_psel),
		.penable   (cpu_penable),
		.pwrite    (cpu_pwrite),
		.paddr     (cpu_paddr),
		.pwdata    (cpu_pwdata),
		.prdata    (cpu_prdata),
		.pready    (cpu_pready),
		.pslverr   (cpu_pslverr),
		.mem       (cpu_req.master)
	);

	mem_arbiter #(.ADDR_W(ADDR_W)) arbiter_inst (
		.clk       (clk),
		.reset_nes (reset_nes),
		.loader    (loader_req.slave),
		.cpu       (cpu_req.slave),
		.ram       (ram_bus.master)
	);

	game_ram #(.ADDR_W(ADDR_W)) ram_inst (
		.clk (clk),
		.ram (ram_bus.slave)
	);

endmodule

// ==== tb_nes_loader_props.sv ====
////////////////////////////////////////////////////////////////////////////
// Loader protocol assertions
// Bound into the iNES loader, checks APB error timing and state holding
////////////////////////////////////////////////////////////////////////////

module tb_nes_loader_props import ines_pkg::*; (
	input logic        clk,
	input logic        reset_nes,
	input logic        pready,
	input logic        pslverr,
	input logic        busy,
	input logic        done,
	input logic        restart,
	input load_state_e state
);

	// pslverr only counts in the completing cycle
	slverr_with_ready: assert property (
		@(posedge clk) disable iff (reset_nes) pslverr |-> pready
	) else $error("pslverr high while pready is low");

	busy_not_done: assert property (
		@(posedge clk) disable iff (reset_nes) !(busy && done)
	) else $error("busy and done high together");

	// Final states are left only through a restart
	final_state_held: assert property (
		@(posedge clk) disable iff (reset_nes)
		(state inside {S_ERROR, S_DONE}) && !restart |=> state == $past(state)
	) else $error("loader left its final state without a restart");

endmodule

bind ines_loader tb_nes_loader_props props_inst (
	.clk       (clk),
	.reset_nes (reset_nes),
	.pready    (pready),
	.pslverr   (pslverr),
	.busy      (busy),
	.done      (done),
	.restart   (restart),
	.state     (state)
);

// ==== tb_nes_loader.sv ====
////////////////////////////////////////////////////////////////////////////
// Cartridge loader testbench
// Directed tests over the download and CPU APB ports of the loader top
////////////////////////////////////////////////////////////////////////////

module tb_nes_loader import mem_bus_pkg::*, ines_pkg::*; ();

	localparam int ADDR_W        = 12;
	localparam int PRG_PAGE_LOG2 = 8;
	localparam int CHR_PAGE_LOG2 = 7;
	localparam int CHR_BASE      = 2048;
	localparam int CLK_PERIOD    = 20;
	localparam int RESET_CYCLES  = 16;
	localparam logic [ADDR_W-1:0] SCRATCH = 12'hF00;  // Above both regions

	// Download transfers per test, header plus payload plus restarts, then state reads
	localparam int DL_TRANSFERS  = (16 + 512 + 384) + (2 * 17 + 2) + (17 + 256)
		+ (17 + 512 + 128) + (17 + 256 + 128) + 9;
	localparam int CPU_TRANSFERS = 200;
	localparam int WORST_CYCLES  = 8;                  // Setup, access and arbiter stalls
	localparam int WATCHDOG_TIME = (RESET_CYCLES + (DL_TRANSFERS + CPU_TRANSFERS)
		* WORST_CYCLES) * CLK_PERIOD;

	logic              clk, reset_nes;
	logic              dl_psel, dl_penable, dl_pwrite;
	logic [7:0]        dl_paddr;
	byte_t             dl_pwdata, dl_prdata;
	logic              dl_pready, dl_pslverr;
	logic              cpu_psel, cpu_penable, cpu_pwrite;
	logic [ADDR_W-1:0] cpu_paddr;
	byte_t             cpu_pwdata, cpu_prdata;
	logic              cpu_pready, cpu_pslverr;
	logic              invert_mirroring;
	logic [31:0]       mapper_flags;
	logic              busy, done, error;

	byte_t       hdr [0:HDR_LEN-1];
	byte_t       model [0:2**ADDR_W-1];             // Expected memory contents
	logic [31:0] lfsr;
	int          checks, errors;

	nes_loader_top #(
		.ADDR_W        (ADDR_W),
		.PRG_PAGE_LOG2 (PRG_PAGE_LOG2),
		.CHR_PAGE_LOG2 (CHR_PAGE_LOG2),
		.CHR_BASE      (CHR_BASE)
	) nes_loader_top_inst (.*);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	initial begin
		#(WATCHDOG_TIME);
		$display("Watchdog timeout: the tests did not finish within %0d time units",
			WATCHDOG_TIME);
		$display("TEST RESULT: FAIL");
		$finish;
	end

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("ERROR: t=%0t %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	task automatic rand_byte(output byte_t b);
		b = '0;
		for (int i = 0; i < 8; i++) begin
			b[i] = lfsr[0];
			lfsr = lfsr_step(lfsr);
		end
	endtask

	function automatic byte_t scratch_byte(input logic [ADDR_W-1:0] a);
		return a[7:0] ^ {a[11:8], a[11:8]} ^ 8'h5A;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// APB masters, called and returning 1 unit after a rising edge
	////////////////////////////////////////////////////////////////////////////
	task automatic dl_write(input logic [7:0] addr, input byte_t data, output logic slverr);
		dl_psel    = 1'b1;
		dl_penable = 1'b0;
		dl_pwrite  = 1'b1;
		dl_paddr   = addr;
		dl_pwdata  = data;
		@(posedge clk);
		#1;
		dl_penable = 1'b1;
		@(negedge clk);
		while (!dl_pready)
			@(negedge clk);
		slverr = dl_pslverr;
		@(posedge clk);
		#1;
		dl_psel    = 1'b0;
		dl_penable = 1'b0;
	endtask

	task automatic dl_read(input logic [7:0] addr, output byte_t data);
		dl_psel    = 1'b1;
		dl_penable = 1'b0;
		dl_pwrite  = 1'b0;
		dl_paddr   = addr;
		@(posedge clk);
		#1;
		dl_penable = 1'b1;
		@(negedge clk);
		check_value("dl_pready", dl_pready, 1);      // No wait state on reads
		while (!dl_pready)
			@(negedge clk);
		data = dl_prdata;
		check_value("dl_pslverr", dl_pslverr, 0);
		@(posedge clk);
		#1;
		dl_psel    = 1'b0;
		dl_penable = 1'b0;
	endtask

	task automatic cpu_write(input logic [ADDR_W-1:0] addr, input byte_t data);
		cpu_psel    = 1'b1;
		cpu_penable = 1'b0;
		cpu_pwrite  = 1'b1;
		cpu_paddr   = addr;
		cpu_pwdata  = data;
		@(posedge clk);
		#1;
		cpu_penable = 1'b1;
		@(negedge clk);
		while (!cpu_pready)
			@(negedge clk);
		check_value("cpu_pslverr", cpu_pslverr, 0);
		@(posedge clk);
		#1;
		cpu_psel    = 1'b0;
		cpu_penable = 1'b0;
	endtask

	task automatic cpu_read(input logic [ADDR_W-1:0] addr, output byte_t data);
		cpu_psel    = 1'b1;
		cpu_penable = 1'b0;
		cpu_pwrite  = 1'b0;
		cpu_paddr   = addr;
		@(posedge clk);
		#1;
		cpu_penable = 1'b1;
		@(negedge clk);
		while (!cpu_pready)
			@(negedge clk);
		data = cpu_prdata;
		check_value("cpu_pslverr", cpu_pslverr, 0);
		@(posedge clk);
		#1;
		cpu_psel    = 1'b0;
		cpu_penable = 1'b0;
	endtask

	// Loader state as seen on the download read port
	task automatic verify_state(input load_state_e exp);
		byte_t st;
		dl_read(DL_DATA_ADDR, st);
		check_value("dl_prdata", st, exp);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Image building and reference flags
	////////////////////////////////////////////////////////////////////////////
	task automatic make_header(input byte_t prg, input byte_t chr, input byte_t f6,
		input byte_t f7);
		for (int i = 0; i < 4; i++)
			hdr[i] = NES_MAGIC[31 - 8 * i -: 8];
		hdr[4] = prg;
		hdr[5] = chr;
		hdr[6] = f6;
		hdr[7] = f7;
		for (int i = 8; i < HDR_LEN; i++)
			hdr[i] = 8'h00;
	endtask

	task automatic send_header();
		logic err;
		for (int i = 0; i < HDR_LEN; i++) begin
			dl_write(DL_DATA_ADDR, hdr[i], err);
			check_value("dl_pslverr", err, 0);
		end
	endtask

	// PRG pages from 0, then CHR pages from CHR_BASE
	task automatic send_payload();
		int    prg_len, chr_len;
		byte_t b;
		logic  err;
		prg_len = int'(hdr[4]) << PRG_PAGE_LOG2;
		chr_len = int'(hdr[5]) << CHR_PAGE_LOG2;
		for (int i = 0; i < prg_len + chr_len; i++) begin
			rand_byte(b);
			if (i < prg_len)
				model[i] = b;
			else
				model[CHR_BASE + i - prg_len] = b;
			dl_write(DL_DATA_ADDR, b, err);
			check_value("dl_pslverr", err, 0);
		end
	endtask

	function automatic logic [2:0] size_code(input byte_t n);
		int k;
		k = 0;
		if (n > 8'd1) begin
			k = 1;
			while (k < 7 && (1 << k) < int'(n))
				k++;
		end
		return 3'(k);
	endfunction

	function automatic logic [31:0] expected_flags(input logic inv);
		logic [31:0] f;
		logic        nes2, dirty;
		f     = '0;
		nes2  = (hdr[7][3:2] == 2'b10);
		dirty = 1'b0;
		if (!nes2) begin
			dirty = (hdr[9][7:1] != 7'd0);
			for (int i = 10; i < HDR_LEN; i++)
				dirty = dirty || (hdr[i] != 8'h00);
		end
		f[FLAG_MAPPER_LSB +: 4]     = hdr[6][7:4];
		f[FLAG_MAPPER_LSB + 4 +: 4] = dirty ? 4'h0 : hdr[7][7:4];
		f[FLAG_PRG_SIZE_LSB +: 3]   = size_code(hdr[4]);
		f[FLAG_CHR_SIZE_LSB +: 3]   = size_code(hdr[5]);
		f[FLAG_MIRROR]              = hdr[6][0] ^ inv;
		f[FLAG_CHR_RAM]             = (hdr[5] == 8'h00);
		f[FLAG_FOUR_SCREEN]         = hdr[6][3];
		if (nes2)
			f[FLAG_SUBMAPPER_LSB +: 8] = hdr[8];
		f[FLAG_SAVES]               = hdr[6][1];
		return f;
	endfunction

	task automatic compare_region(input int base, input int len, input int step);
		byte_t got;
		for (int i = 0; i < len; i += step) begin
			cpu_read(ADDR_W'(base + i), got);
			check_value("cpu_prdata", got, model[base + i]);
		end
		cpu_read(ADDR_W'(base + len - 1), got);   // Last byte of the region
		check_value("cpu_prdata", got, model[base + len - 1]);
	endtask

	task automatic restart_loader();
		logic err;
		dl_write(DL_RESTART_ADDR, 8'h00, err);
		check_value("dl_pslverr", err, 0);
		check_value("done", done, 0);
		check_value("error", error, 0);
		check_value("busy", busy, 0);
		check_value("mapper_flags", mapper_flags, 0);
		verify_state(S_HEADER);
	endtask

	task automatic check_good_load(input logic inv);
		check_value("done", done, 1);
		check_value("error", error, 0);
		check_value("busy", busy, 0);
		check_value("mapper_flags", mapper_flags, expected_flags(inv));
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Directed tests
	////////////////////////////////////////////////////////////////////////////
	task automatic valid_load();
		make_header(8'd2, 8'd3, 8'h43, 8'h00);         // Mapper 4, vertical, battery
		send_header();
		check_value("busy", busy, 1);
		verify_state(S_PRG);
		send_payload();
		check_good_load(1'b0);
		check_value("prg size code", mapper_flags[FLAG_PRG_SIZE_LSB +: 3], 1);
		check_value("chr size code", mapper_flags[FLAG_CHR_SIZE_LSB +: 3], 2);
		check_value("mapper", mapper_flags[FLAG_MAPPER_LSB +: 8], 4);
		verify_state(S_DONE);
	endtask

	task automatic memory_readback();
		compare_region(0, 512, 37);
		compare_region(CHR_BASE, 384, 29);
	endtask

	task automatic expect_rejected();
		logic err;
		check_value("error", error, 1);
		check_value("done", done, 1);
		check_value("mapper_flags", mapper_flags, 0);
		verify_state(S_ERROR);
		dl_write(DL_DATA_ADDR, 8'hAA, err);
		check_value("dl_pslverr", err, 1);
	endtask

	task automatic bad_header();
		restart_loader();
		make_header(8'd2, 8'd1, 8'h00, 8'h00);
		hdr[0] = 8'h4D;
		send_header();
		expect_rejected();
		restart_loader();
		make_header(8'd2, 8'd1, 8'h04, 8'h00);         // Trainer present
		send_header();
		expect_rejected();
	endtask

	task automatic chr_ram_dirty_header();
		restart_loader();
		make_header(8'd1, 8'd0, 8'h21, 8'h20);
		hdr[12] = 8'h55;                              // Junk in the padding
		invert_mirroring = 1'b1;
		send_header();
		send_payload();
		check_good_load(1'b1);
		check_value("chr ram flag", mapper_flags[FLAG_CHR_RAM], 1);
		check_value("mirror flag", mapper_flags[FLAG_MIRROR], 0);
		check_value("mapper high nibble", mapper_flags[FLAG_MAPPER_LSB + 4 +: 4], 0);
		invert_mirroring = 1'b0;
	endtask

	task automatic cpu_during_load();
		byte_t             got;
		logic [ADDR_W-1:0] a;
		restart_loader();
		make_header(8'd2, 8'd1, 8'h10, 8'h00);
		fork
			begin
				send_header();
				send_payload();
			end
			begin
				wait (busy);
				@(posedge clk);
				#1;
				for (int i = 0; i < 8; i++) begin
					a = SCRATCH + ADDR_W'(3 * i);
					model[a] = scratch_byte(a);
					cpu_write(a, model[a]);
				end
				for (int i = 0; i < 8; i++) begin
					a = SCRATCH + ADDR_W'(3 * i);
					cpu_read(a, got);
					check_value("cpu_prdata", got, model[a]);
				end
				check_value("busy", busy, 1);        // CPU traffic overlapped the load
			end
		join
		check_good_load(1'b0);
		compare_region(0, 512, 41);
		compare_region(CHR_BASE, 128, 19);
	endtask

	task automatic restart_and_reload();
		check_value("done", done, 1);
		restart_loader();
		make_header(8'd1, 8'd1, 8'h18, 8'h18);         // NES 2.0, four screen
		hdr[8] = 8'h23;
		send_header();
		send_payload();
		check_good_load(1'b0);
		compare_region(0, 256, 31);
		compare_region(CHR_BASE, 128, 23);
	endtask

	initial begin
		lfsr             = 32'h6dfa_e208;
		checks           = 0;
		errors           = 0;
		reset_nes        = 1'b1;
		dl_psel          = 1'b0;
		dl_penable       = 1'b0;
		dl_pwrite        = 1'b0;
		dl_paddr         = '0;
		dl_pwdata        = '0;
		cpu_psel         = 1'b0;
		cpu_penable      = 1'b0;
		cpu_pwrite       = 1'b0;
		cpu_paddr        = '0;
		cpu_pwdata       = '0;
		invert_mirroring = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		#1;
		reset_nes = 1'b0;
		check_value("busy", busy, 0);
		check_value("done", done, 0);
		check_value("error", error, 0);
		check_value("dl_pready", dl_pready, 0);
		check_value("cpu_pready", cpu_pready, 0);

		valid_load();
		memory_readback();
		bad_header();
		chr_ram_dirty_header();
		cpu_during_load();
		restart_and_reload();

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

// ==== nes_loader.f ====
mem_bus_pkg.sv
ines_pkg.sv
bus_ifs.sv
game_ram.sv
mem_arbiter.sv
cpu_port.sv
ines_loader.sv
nes_loader_top.sv
tb_nes_loader_props.sv
tb_nes_loader.sv

// ==== Makefile ====
# Verilator build for the cartridge loader testbench

VERILATOR  ?= verilator
TOP        ?= tb_nes_loader
FILELIST   ?= nes_loader.f
OBJ_DIR    ?= obj_dir
LINT_FLAGS ?= --lint-only --timing -Wall
SIM_FLAGS  ?= --binary --timing --assert -Wno-fatal
PASS_MSG   ?= TEST RESULT: PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
